/* Makefile */
TOOL       := verilator
TOP        := tb_issue
FILELIST   := tb.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
SIM_BIN    := $(BUILD_DIR)/V$(TOP)
PASS_TEXT  := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* issue_alu_bank.sv */
`timescale 1ns/10ps

module issue_alu_bank #(
    parameter int SLOTS = 16
) (
    input  logic                             w_fire00_1,
    input  logic                             rstn,
    input  logic                             i_strobe,
    input  issue_pkg::slot_t [SLOTS-1:0]     i_slots,
    input  logic [SLOTS-1:0]                 i_take,
    input  logic                             i_flush,
    output logic [SLOTS-1:0]                 o_valid,
    output issue_pkg::inst_t [SLOTS-1:0]     o_inst
);

    logic [SLOTS-1:0] alu_mask;

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            alu_mask[i] = (i_slots[i].cls == issue_pkg::CLASS_ALU);
        end
    end

    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            o_valid <= '0;
        end else if (i_flush) begin
            o_valid <= '0;
        end else if (i_strobe) begin
            // new window replaces the bank, takes are dropped
            o_valid <= alu_mask;
        end else begin
            o_valid <= o_valid & ~i_take;
        end
    end

    always_ff @(posedge w_fire00_1) begin
        if (i_strobe) begin
            for (int i = 0; i < SLOTS; i++) begin
                o_inst[i] <= i_slots[i].inst;
            end
        end
    end

endmodule

/* issue_classify.sv */
`timescale 1ns/10ps

module issue_classify #(
    parameter int SLOTS = 16
) (
    input  logic                             w_fire00_1,
    input  logic                             rstn,
    input  logic                             i_strobe,
    input  logic [SLOTS-1:0]                 i_valid_mask,
    input  issue_pkg::inst_t [SLOTS-1:0]     i_win,
    input  logic                             i_flush,
    output logic                             o_strobe,
    output issue_pkg::slot_t [SLOTS-1:0]     o_slots
);

    issue_pkg::slot_t [SLOTS-1:0] slot_next;

    function automatic issue_pkg::inst_class_e decode_class(
        input issue_pkg::opcode_t op
    );
        issue_pkg::inst_class_e cls;
        case (op)
            issue_pkg::OPC_LOAD,
            issue_pkg::OPC_STORE,
            issue_pkg::OPC_AMO: begin
                cls = issue_pkg::CLASS_LSU;
            end
            issue_pkg::OPC_SYSTEM: begin
                cls = issue_pkg::CLASS_CSR;
            end
            default: begin
                cls = issue_pkg::CLASS_ALU;
            end
        endcase
        return cls;
    endfunction

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            slot_next[i].inst = i_win[i];
            if (i_valid_mask[i]) begin
                slot_next[i].cls = decode_class(issue_pkg::opcode_t'(i_win[i][6:0]));
            end else begin
                // cut off by the branch
                slot_next[i].cls = issue_pkg::CLASS_NONE;
            end
        end
    end

    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            o_strobe <= 1'b0;
        end else begin
            o_strobe <= i_strobe && !i_flush;
        end
    end

    always_ff @(posedge w_fire00_1) begin
        if (i_strobe) begin
            o_slots <= slot_next;
        end
    end

endmodule

/* issue_pkg.sv */
package issue_pkg;

    // one decoded instruction word
    localparam int INST_W = 73;

    typedef logic [INST_W-1:0] inst_t;

    // opcode sits in the low 7 bits of inst_t
    typedef logic [6:0] opcode_t;

    // opcodes that leave the ALU path
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_AMO    = 7'b0101111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [1:0] {
        CLASS_NONE = 2'd0,
        CLASS_ALU  = 2'd1,
        CLASS_LSU  = 2'd2,
        CLASS_CSR  = 2'd3
    } inst_class_e;

    // one classified window slot
    typedef struct packed {
        inst_class_e cls;
        inst_t       inst;
    } slot_t;

    // oldest queue entry
    typedef struct packed {
        logic  valid;
        inst_t inst;
    } queue_head_t;

endpackage

/* issue_queue.sv */
`timescale 1ns/10ps

module issue_queue #(
    parameter int                     SLOTS       = 16,
    parameter int                     QUEUE_DEPTH = 32,
    parameter issue_pkg::inst_class_e MATCH_CLASS = issue_pkg::CLASS_LSU
) (
    input  logic                                 w_fire00_1,
    input  logic                                 rstn,
    input  logic                                 i_strobe,
    input  issue_pkg::slot_t [SLOTS-1:0]         i_slots,
    input  logic                                 i_pop,
    input  logic                                 i_flush,
    output issue_pkg::queue_head_t               o_head,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]     o_count
);

    // depth is a power of two, so pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH+1);
    localparam int OFF_W = $clog2(SLOTS+1);

    issue_pkg::inst_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [SLOTS-1:0] match;
    logic [OFF_W-1:0] offset [SLOTS];
    logic [OFF_W-1:0] run;
    logic [OFF_W-1:0] n_wr;
    logic             pop_ok;

    // prefix count gives each matching slot its place after the tail
    always_comb begin
        run = '0;
        for (int i = 0; i < SLOTS; i++) begin
            match[i]  = i_strobe && (i_slots[i].cls == MATCH_CLASS);
            offset[i] = run;
            if (match[i]) begin
                run = run + 1'b1;
            end
        end
        n_wr = run;
    end

    // pop on empty is ignored
    assign pop_ok = i_pop && (count != '0);

    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_ok);
            wr_ptr <= wr_ptr + PTR_W'(n_wr);
            count  <= count + CNT_W'(n_wr) - CNT_W'(pop_ok);
        end
    end

    always_ff @(posedge w_fire00_1) begin
        for (int i = 0; i < SLOTS; i++) begin
            if (match[i]) begin
                mem[wr_ptr + PTR_W'(offset[i])] <= i_slots[i].inst;
            end
        end
    end

    assign o_head.valid = (count != '0);
    assign o_head.inst  = mem[rd_ptr];
    assign o_count      = count;

    // no back-pressure, so the writer must never overfill
    a_no_overflow : assert property (
        @(posedge w_fire00_1) disable iff (!rstn)
        !i_flush |-> (int'(count) + int'(n_wr) - int'(pop_ok) <= QUEUE_DEPTH)
    ) else $error("queue overflow: count %0d plus %0d writes", count, n_wr);

endmodule

/* issue_top.sv */
`timescale 1ns/10ps

module issue_top #(
    parameter int SLOTS       = 16,
    parameter int QUEUE_DEPTH = 32
) (
    input  logic                                 w_fire00_1,
    input  logic                                 rstn,
    input  logic                                 i_win_strobe,
    input  issue_pkg::inst_t [SLOTS-1:0]         i_win,
    input  logic                                 i_branch_valid,
    input  logic [$clog2(SLOTS)-1:0]             i_branch_index,
    input  logic                                 i_flush,
    input  logic                                 i_lsu_pop,
    input  logic                                 i_csr_pop,
    input  logic [SLOTS-1:0]                     i_alu_take,
    output issue_pkg::queue_head_t               o_lsu_head,
    output issue_pkg::queue_head_t               o_csr_head,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]     o_lsu_count,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]     o_csr_count,
    output logic [SLOTS-1:0]                     o_alu_valid,
    output issue_pkg::inst_t [SLOTS-1:0]         o_alu_inst
);

    logic                         win_strobe;
    logic [SLOTS-1:0]             win_mask;
    issue_pkg::inst_t [SLOTS-1:0] win_data;
    logic                         cls_strobe;
    issue_pkg::slot_t [SLOTS-1:0] cls_slots;

    issue_window_in #(.SLOTS(SLOTS)) u_window_in (
        .w_fire00_1     (w_fire00_1),
        .rstn           (rstn),
        .i_win_strobe   (i_win_strobe),
        .i_win          (i_win),
        .i_branch_valid (i_branch_valid),
        .i_branch_index (i_branch_index),
        .i_flush        (i_flush),
        .o_strobe       (win_strobe),
        .o_valid_mask   (win_mask),
        .o_win          (win_data)
    );

    issue_classify #(.SLOTS(SLOTS)) u_classify (
        .w_fire00_1   (w_fire00_1),
        .rstn         (rstn),
        .i_strobe     (win_strobe),
        .i_valid_mask (win_mask),
        .i_win        (win_data),
        .i_flush      (i_flush),
        .o_strobe     (cls_strobe),
        .o_slots      (cls_slots)
    );

    issue_queue #(
        .SLOTS       (SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MATCH_CLASS (issue_pkg::CLASS_LSU)
    ) u_lsu_queue (
        .w_fire00_1 (w_fire00_1),
        .rstn       (rstn),
        .i_strobe   (cls_strobe),
        .i_slots    (cls_slots),
        .i_pop      (i_lsu_pop),
        .i_flush    (i_flush),
        .o_head     (o_lsu_head),
        .o_count    (o_lsu_count)
    );

    issue_queue #(
        .SLOTS       (SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MATCH_CLASS (issue_pkg::CLASS_CSR)
    ) u_csr_queue (
        .w_fire00_1 (w_fire00_1),
        .rstn       (rstn),
        .i_strobe   (cls_strobe),
        .i_slots    (cls_slots),
        .i_pop      (i_csr_pop),
        .i_flush    (i_flush),
        .o_head     (o_csr_head),
        .o_count    (o_csr_count)
    );

    issue_alu_bank #(.SLOTS(SLOTS)) u_alu_bank (
        .w_fire00_1 (w_fire00_1),
        .rstn       (rstn),
        .i_strobe   (cls_strobe),
        .i_slots    (cls_slots),
        .i_take     (i_alu_take),
        .i_flush    (i_flush),
        .o_valid    (o_alu_valid),
        .o_inst     (o_alu_inst)
    );

endmodule

/* issue_window_in.sv */
`timescale 1ns/10ps

module issue_window_in #(
    parameter int SLOTS = 16
) (
    input  logic                             w_fire00_1,
    input  logic                             rstn,
    input  logic                             i_win_strobe,
    input  issue_pkg::inst_t [SLOTS-1:0]     i_win,
    input  logic                             i_branch_valid,
    input  logic [$clog2(SLOTS)-1:0]         i_branch_index,
    input  logic                             i_flush,
    output logic                             o_strobe,
    output logic [SLOTS-1:0]                 o_valid_mask,
    output issue_pkg::inst_t [SLOTS-1:0]     o_win
);

    logic [SLOTS-1:0] cut_mask;

    // slots after the first branch are dropped
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            cut_mask[i] = !i_branch_valid || (i <= int'(i_branch_index));
        end
    end

    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            o_strobe <= 1'b0;
        end else begin
            // a window arriving with a flush is lost
            o_strobe <= i_win_strobe && !i_flush;
        end
    end

    always_ff @(posedge w_fire00_1) begin
        if (i_win_strobe) begin
            o_valid_mask <= cut_mask;
            o_win        <= i_win;
        end
    end

    // branch index must point inside the window
    a_branch_in_window : assert property (
        @(posedge w_fire00_1) disable iff (!rstn)
        (i_win_strobe && i_branch_valid) |-> (int'(i_branch_index) < SLOTS)
    ) else $error("branch index %0d outside window of %0d slots",
                  i_branch_index, SLOTS);

endmodule

/* tb.f */
issue_pkg.sv
issue_window_in.sv
issue_classify.sv
issue_queue.sv
issue_alu_bank.sv
issue_top.sv
tb_issue.sv

/* tb_issue.sv */
`timescale 1ns/10ps

module tb_issue;

    localparam int SLOTS       = 16;
    localparam int QUEUE_DEPTH = 32;
    localparam int CNT_W       = $clog2(QUEUE_DEPTH+1);
    localparam int IDX_W       = $clog2(SLOTS);
    localparam int WAIT_LIMIT  = 8;
    localparam int KIND_ALU    = 0;
    localparam int KIND_LSU    = 1;
    localparam int KIND_CSR    = 2;

    logic                         w_fire00_1;
    logic                         rstn;
    logic                         win_strobe;
    issue_pkg::inst_t [SLOTS-1:0] win;
    logic                         branch_valid;
    logic [IDX_W-1:0]             branch_index;
    logic                         flush;
    logic                         lsu_pop;
    logic                         csr_pop;
    logic [SLOTS-1:0]             alu_take;
    issue_pkg::queue_head_t       lsu_head;
    issue_pkg::queue_head_t       csr_head;
    logic [CNT_W-1:0]             lsu_count;
    logic [CNT_W-1:0]             csr_count;
    logic [SLOTS-1:0]             alu_valid;
    issue_pkg::inst_t [SLOTS-1:0] alu_inst;

    // reference model state
    issue_pkg::inst_t             lsu_q[$];
    issue_pkg::inst_t             csr_q[$];
    logic [SLOTS-1:0]             exp_valid;
    issue_pkg::inst_t [SLOTS-1:0] exp_inst;

    issue_pkg::inst_t [SLOTS-1:0] first_win;
    issue_pkg::inst_t [SLOTS-1:0] second_win;
    logic [SLOTS-1:0]             take;

    integer seed = 32'h4c42aa60;
    int     errors;
    int     checks;
    int     tests;
    int     test_errors;
    string  test_name;

    issue_pkg::opcode_t opc_table [6] = '{
        issue_pkg::OPC_LOAD, issue_pkg::OPC_STORE, issue_pkg::OPC_AMO,
        issue_pkg::OPC_SYSTEM, 7'b0110011, 7'b0010011
    };

    issue_top #(
        .SLOTS       (SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_issue_top (
        .w_fire00_1     (w_fire00_1),
        .rstn           (rstn),
        .i_win_strobe   (win_strobe),
        .i_win          (win),
        .i_branch_valid (branch_valid),
        .i_branch_index (branch_index),
        .i_flush        (flush),
        .i_lsu_pop      (lsu_pop),
        .i_csr_pop      (csr_pop),
        .i_alu_take     (alu_take),
        .o_lsu_head     (lsu_head),
        .o_csr_head     (csr_head),
        .o_lsu_count    (lsu_count),
        .o_csr_count    (csr_count),
        .o_alu_valid    (alu_valid),
        .o_alu_inst     (alu_inst)
    );

    initial begin
        w_fire00_1 = 1'b0;
        forever #2 w_fire00_1 = ~w_fire00_1;
    end

    // a flush leaves both queues and the bank empty at the next edge
    a_flush_empties : assert property (
        @(posedge w_fire00_1) disable iff (!rstn)
        flush |=> (lsu_count == '0 && csr_count == '0 && alu_valid == '0 &&
                   !lsu_head.valid && !csr_head.valid)
    ) else begin
        $display("CHECK FAILED %s flush empties: expected 0 0 0 actual %0d %0d %0h",
                 test_name, $sampled(lsu_count), $sampled(csr_count),
                 $sampled(alu_valid));
        errors++;
    end

    task automatic tick();
        @(posedge w_fire00_1);
        #1;
    endtask

    task automatic check_value(input string what, input issue_pkg::inst_t expected,
                               input issue_pkg::inst_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    function automatic int opcode_kind(input issue_pkg::opcode_t op);
        if (op == issue_pkg::OPC_LOAD || op == issue_pkg::OPC_STORE ||
            op == issue_pkg::OPC_AMO) begin
            return KIND_LSU;
        end
        if (op == issue_pkg::OPC_SYSTEM) begin
            return KIND_CSR;
        end
        return KIND_ALU;
    endfunction

    task automatic make_window();
        logic [95:0] raw;
        int          idx;
        for (int i = 0; i < SLOTS; i++) begin
            raw = {$random(seed), $random(seed), $random(seed)};
            idx = int'($unsigned($random(seed)) % 32'd6);
            win[i] = raw[issue_pkg::INST_W-1:0];
            win[i][6:0] = opc_table[idx];
        end
        // one CSR and one LSU slot below any cutoff used here
        win[0][6:0] = issue_pkg::OPC_SYSTEM;
        win[1][6:0] = issue_pkg::OPC_LOAD;
    endtask

    task automatic apply_window(input issue_pkg::inst_t [SLOTS-1:0] w, input logic bv,
                                input logic [IDX_W-1:0] bidx);
        exp_valid = '0;
        for (int i = 0; i < SLOTS; i++) begin
            if (!bv || i <= int'(bidx)) begin
                case (opcode_kind(w[i][6:0]))
                    KIND_LSU: lsu_q.push_back(w[i]);
                    KIND_CSR: csr_q.push_back(w[i]);
                    default:  exp_valid[i] = 1'b1;
                endcase
            end
        end
        exp_inst = w;
    endtask

    task automatic check_outputs();
        check_value("lsu count", issue_pkg::inst_t'(lsu_q.size()), issue_pkg::inst_t'(lsu_count));
        check_value("csr count", issue_pkg::inst_t'(csr_q.size()), issue_pkg::inst_t'(csr_count));
        check_value("lsu head valid", issue_pkg::inst_t'(lsu_q.size() != 0),
                    issue_pkg::inst_t'(lsu_head.valid));
        check_value("csr head valid", issue_pkg::inst_t'(csr_q.size() != 0),
                    issue_pkg::inst_t'(csr_head.valid));
        if (lsu_q.size() != 0) begin
            check_value("lsu head", lsu_q[0], lsu_head.inst);
        end
        if (csr_q.size() != 0) begin
            check_value("csr head", csr_q[0], csr_head.inst);
        end
        check_value("alu valid", issue_pkg::inst_t'(exp_valid), issue_pkg::inst_t'(alu_valid));
        for (int i = 0; i < SLOTS; i++) begin
            if (exp_valid[i]) begin
                check_value($sformatf("alu slot %0d", i), exp_inst[i], alu_inst[i]);
            end
        end
    endtask

    function automatic logic outputs_match();
        return lsu_count == CNT_W'(lsu_q.size()) && csr_count == CNT_W'(csr_q.size()) &&
               alu_valid == exp_valid;
    endfunction

    // model already holds the state the window will produce
    task automatic send_window(input logic bv, input logic [IDX_W-1:0] bidx);
        make_window();
        win_strobe   = 1'b1;
        branch_valid = bv;
        branch_index = bidx;
        tick();
        win_strobe   = 1'b0;
        branch_valid = 1'b0;
        apply_window(win, bv, bidx);
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while (!outputs_match() && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!outputs_match()) begin
            $display("test %s timed out waiting for the window to reach the outputs",
                     test_name);
            errors++;
        end else begin
            check_value("latency", issue_pkg::inst_t'(2), issue_pkg::inst_t'(cycles));
        end
    endtask

    task automatic drain_queues();
        int guard;
        guard = 0;
        while ((lsu_q.size() != 0 || csr_q.size() != 0) && guard < 2*QUEUE_DEPTH) begin
            check_outputs();
            lsu_pop = (lsu_q.size() != 0);
            csr_pop = (csr_q.size() != 0);
            tick();
            lsu_pop = 1'b0;
            csr_pop = 1'b0;
            if (lsu_q.size() != 0) begin
                void'(lsu_q.pop_front());
            end
            if (csr_q.size() != 0) begin
                void'(csr_q.pop_front());
            end
            guard++;
        end
        if (guard >= 2*QUEUE_DEPTH) begin
            $display("test %s timed out draining the queues", test_name);
            errors++;
        end
        check_outputs();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    initial begin
        rstn         = 1'b0;
        win_strobe   = 1'b0;
        win          = '0;
        branch_valid = 1'b0;
        branch_index = '0;
        flush        = 1'b0;
        lsu_pop      = 1'b0;
        csr_pop      = 1'b0;
        alu_take     = '0;
        exp_valid    = '0;
        exp_inst     = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (2) @(posedge w_fire00_1);
        #1;
        rstn = 1'b1;

        start_test("reset");
        check_outputs();
        end_test();

        start_test("classify");
        send_window(1'b0, '0);
        wait_for_results();
        check_outputs();
        drain_queues();
        end_test();

        start_test("branch cutoff");
        send_window(1'b1, IDX_W'(5));
        wait_for_results();
        check_outputs();
        check_value("alu above cutoff", '0, issue_pkg::inst_t'(alu_valid >> 6));
        drain_queues();
        end_test();

        start_test("accumulate");
        // pop on empty queues
        lsu_pop = 1'b1;
        csr_pop = 1'b1;
        tick();
        lsu_pop = 1'b0;
        csr_pop = 1'b0;
        check_outputs();
        make_window();
        first_win  = win;
        win_strobe = 1'b1;
        tick();
        make_window();
        second_win = win;
        tick();
        win_strobe = 1'b0;
        tick();
        apply_window(first_win, 1'b0, '0);
        check_outputs();
        // pop lands on the same edge as the second write
        lsu_pop = 1'b1;
        csr_pop = 1'b1;
        tick();
        lsu_pop = 1'b0;
        csr_pop = 1'b0;
        void'(lsu_q.pop_front());
        void'(csr_q.pop_front());
        apply_window(second_win, 1'b0, '0);
        check_outputs();
        drain_queues();
        end_test();

        start_test("alu take");
        send_window(1'b0, '0);
        wait_for_results();
        check_outputs();
        take     = exp_valid & SLOTS'($random(seed));
        alu_take = take;
        tick();
        alu_take  = '0;
        exp_valid = exp_valid & ~take;
        check_outputs();
        // takes held across the reload must not touch the new bank
        alu_take = '1;
        send_window(1'b0, '0);
        wait_for_results();
        alu_take = '0;
        check_outputs();
        drain_queues();
        end_test();

        start_test("flush");
        send_window(1'b0, '0);
        wait_for_results();
        check_outputs();
        make_window();
        win_strobe = 1'b1;
        tick();
        win_strobe = 1'b0;
        flush      = 1'b1;
        tick();
        flush = 1'b0;
        lsu_q.delete();
        csr_q.delete();
        exp_valid = '0;
        // in-flight window must stay gone
        for (int i = 0; i < 4; i++) begin
            check_outputs();
            tick();
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
